//--- hw/lda_defines.svh
`ifndef LDA_DEFINES_SVH
`define LDA_DEFINES_SVH

// coordinate and color widths
`define LDA_X_W      9
`define LDA_Y_W      8
`define LDA_COLOR_W  3

// bus side
`define LDA_ADDR_W   3
`define LDA_DATA_W   32

// point word layout on the bus, x low and y above it
`define LDA_PT_X_LSB 0
`define LDA_PT_Y_LSB 9

`endif

//--- hw/lda_asc_pkg.sv
`default_nettype none

package lda_asc_pkg;

  // register selected by a bus address
  typedef enum logic [2:0] {
    NONE,
    MODE,
    STATUS,
    GO,
    START_P,
    END_P,
    COLOR
  } lda_reg_t;

  // how the master waits for a line to finish
  typedef enum logic {
    STALL = 1'b0,  // bus held with waitrequest
    POLL  = 1'b1   // status register reads 1 while busy
  } lda_mode_t;

endpackage

`default_nettype wire

//--- hw/lda_pixel_pkg.sv
`default_nettype none

`include "lda_defines.svh"

package lda_pixel_pkg;

  // y sits above x, same order as the bus point word
  typedef struct packed {
    logic [`LDA_Y_W-1:0] y;
    logic [`LDA_X_W-1:0] x;
  } lda_point_t;

  typedef struct packed {
    logic [`LDA_COLOR_W-1:0] color;
    lda_point_t              pt;
  } lda_pixel_t;

endpackage

`default_nettype wire

//--- hw/lda_pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "lda_defines.svh"

// one pixel per cycle with wr high, no back-pressure
interface lda_pixel_if;

  logic                    wr;
  logic [`LDA_X_W-1:0]     x;
  logic [`LDA_Y_W-1:0]     y;
  logic [`LDA_COLOR_W-1:0] color;

  modport source (
    output wr,
    output x,
    output y,
    output color
  );

  modport sink (
    input wr,
    input x,
    input y,
    input color
  );

endinterface

`default_nettype wire

//--- hw/lda_asc_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "lda_defines.svh"

module lda_asc_control (
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire [`LDA_ADDR_W-1:0]       i_address,
  input  wire                         i_read,
  input  wire                         i_write,
  input  wire                         i_done,
  input  wire lda_asc_pkg::lda_mode_t i_mode,
  output logic                        o_start,
  output logic                        o_waitrequest,
  output logic                        o_status,
  output lda_asc_pkg::lda_reg_t       o_rd_sel,
  output logic                        o_mode_ld,
  output logic                        o_sp_ld,
  output logic                        o_ep_ld,
  output logic                        o_col_ld
);

  typedef enum logic {
    S_WAIT,
    S_RUN
  } state_t;

  state_t                 state_q;
  state_t                 state_d;
  lda_asc_pkg::lda_mode_t run_mode_q;  // mode latched at GO
  logic                   go_ack_q;    // completing beat of a stalled GO
  lda_asc_pkg::lda_reg_t  reg_sel;
  logic                   go_wr;

  always_comb begin : addr_decode
    case (i_address)
      3'd0:    reg_sel = lda_asc_pkg::MODE;
      3'd1:    reg_sel = lda_asc_pkg::STATUS;
      3'd2:    reg_sel = lda_asc_pkg::GO;
      3'd3:    reg_sel = lda_asc_pkg::START_P;
      3'd4:    reg_sel = lda_asc_pkg::END_P;
      3'd5:    reg_sel = lda_asc_pkg::COLOR;
      default: reg_sel = lda_asc_pkg::NONE;
    endcase
  end : addr_decode

  // the held GO write must not start a second line when it finally completes
  assign go_wr = i_write && (reg_sel == lda_asc_pkg::GO) && !go_ack_q;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state_q    <= S_WAIT;
      run_mode_q <= lda_asc_pkg::STALL;
      go_ack_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      go_ack_q <= (state_q == S_RUN) && i_done && (run_mode_q == lda_asc_pkg::STALL);
      if (o_start) run_mode_q <= i_mode;
    end
  end

  always_comb begin : fsm
    o_start       = 1'b0;
    o_status      = 1'b0;
    o_waitrequest = 1'b0;
    state_d       = state_q;
    case (state_q)
      S_WAIT: begin
        if (go_wr) begin
          o_start = 1'b1;
          if (i_mode == lda_asc_pkg::POLL) o_status = 1'b1;
          else o_waitrequest = 1'b1;
          state_d = S_RUN;
        end
      end
      S_RUN: begin
        if (run_mode_q == lda_asc_pkg::POLL) o_status = 1'b1;
        else o_waitrequest = 1'b1;
        if (i_done) state_d = S_WAIT;  // done shares the last pixel cycle
      end
      default: state_d = S_WAIT;
    endcase
  end : fsm

  always_comb begin : strobes
    o_mode_ld = 1'b0;
    o_sp_ld   = 1'b0;
    o_ep_ld   = 1'b0;
    o_col_ld  = 1'b0;
    o_rd_sel  = i_read ? reg_sel : lda_asc_pkg::NONE;
    if (i_write) begin
      case (reg_sel)
        lda_asc_pkg::MODE:    o_mode_ld = 1'b1;
        lda_asc_pkg::START_P: o_sp_ld   = 1'b1;
        lda_asc_pkg::END_P:   o_ep_ld   = 1'b1;
        lda_asc_pkg::COLOR:   o_col_ld  = 1'b1;
        default:              o_mode_ld = 1'b0;  // status, go, unmapped
      endcase
    end
  end : strobes

endmodule

`default_nettype wire

//--- hw/lda_asc_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "lda_defines.svh"

module lda_asc_datapath (
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire [`LDA_DATA_W-1:0]       i_writedata,
  input  wire                         i_mode_ld,
  input  wire                         i_sp_ld,
  input  wire                         i_ep_ld,
  input  wire                         i_col_ld,
  input  wire lda_asc_pkg::lda_reg_t  i_rd_sel,
  input  wire                         i_status,
  output logic [`LDA_DATA_W-1:0]      o_readdata,
  output lda_asc_pkg::lda_mode_t      o_mode,
  output lda_pixel_pkg::lda_point_t   o_start_pt,
  output lda_pixel_pkg::lda_point_t   o_end_pt,
  output logic [`LDA_COLOR_W-1:0]     o_color
);

  lda_pixel_pkg::lda_point_t wr_pt;

  // point word unpacked once, shared by both point registers
  always_comb begin : unpack
    wr_pt.x = i_writedata[`LDA_PT_X_LSB +: `LDA_X_W];
    wr_pt.y = i_writedata[`LDA_PT_Y_LSB +: `LDA_Y_W];
  end : unpack

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_mode     <= lda_asc_pkg::STALL;
      o_start_pt <= '0;
      o_end_pt   <= '0;
      o_color    <= '0;
    end else begin
      if (i_mode_ld) o_mode <= lda_asc_pkg::lda_mode_t'(i_writedata[0]);
      if (i_sp_ld) o_start_pt <= wr_pt;
      if (i_ep_ld) o_end_pt <= wr_pt;
      if (i_col_ld) o_color <= i_writedata[`LDA_COLOR_W-1:0];
    end
  end

  // zero-extended readback, same cycle as the read
  always_comb begin : readback
    o_readdata = '0;
    case (i_rd_sel)
      lda_asc_pkg::MODE: o_readdata[0] = o_mode;
      lda_asc_pkg::STATUS: o_readdata[0] = i_status;
      lda_asc_pkg::START_P: begin
        o_readdata[`LDA_PT_X_LSB +: `LDA_X_W] = o_start_pt.x;
        o_readdata[`LDA_PT_Y_LSB +: `LDA_Y_W] = o_start_pt.y;
      end
      lda_asc_pkg::END_P: begin
        o_readdata[`LDA_PT_X_LSB +: `LDA_X_W] = o_end_pt.x;
        o_readdata[`LDA_PT_Y_LSB +: `LDA_Y_W] = o_end_pt.y;
      end
      lda_asc_pkg::COLOR: o_readdata[`LDA_COLOR_W-1:0] = o_color;
      default: o_readdata = '0;  // go and unmapped read 0
    endcase
  end : readback

endmodule

`default_nettype wire

//--- hw/lda_line_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "lda_defines.svh"

module lda_line_engine (
  input  wire                            i_clk,
  input  wire                            i_reset,
  input  wire                            i_start,
  input  wire lda_pixel_pkg::lda_point_t i_start_pt,
  input  wire lda_pixel_pkg::lda_point_t i_end_pt,
  input  wire [`LDA_COLOR_W-1:0]         i_color,
  output logic                           o_done,
  lda_pixel_if.source                    pix
);

  // room for 2*err with the longest x delta plus sign
  localparam int ERR_W = `LDA_X_W + 3;

  logic                      busy_q;
  lda_pixel_pkg::lda_point_t cur_q;
  lda_pixel_pkg::lda_point_t end_q;
  logic [`LDA_COLOR_W-1:0]   color_q;
  logic                      x_inc_q;
  logic                      y_inc_q;
  logic signed [ERR_W-1:0]   dx_q;
  logic signed [ERR_W-1:0]   dy_q;   // kept negative
  logic signed [ERR_W-1:0]   err_q;
  logic signed [ERR_W-1:0]   dx_raw;
  logic signed [ERR_W-1:0]   dy_raw;
  logic signed [ERR_W-1:0]   dx_abs;
  logic signed [ERR_W-1:0]   dy_neg;
  logic signed [ERR_W-1:0]   err_d;
  logic signed [ERR_W:0]     e2;
  logic                      step_x;
  logic                      step_y;
  logic                      at_end;
  lda_pixel_pkg::lda_pixel_t pix_out;

  always_comb begin : setup
    dx_raw = $signed(ERR_W'(i_end_pt.x)) - $signed(ERR_W'(i_start_pt.x));
    dy_raw = $signed(ERR_W'(i_end_pt.y)) - $signed(ERR_W'(i_start_pt.y));
    dx_abs = dx_raw[ERR_W-1] ? -dx_raw : dx_raw;
    dy_neg = dy_raw[ERR_W-1] ? dy_raw : -dy_raw;
  end : setup

  always_comb begin : walk
    at_end = (cur_q == end_q);
    e2     = $signed({err_q, 1'b0});
    step_x = (e2 >= dy_q);
    step_y = (e2 <= dx_q);
    err_d  = err_q;
    if (step_x) err_d = err_d + dy_q;
    if (step_y) err_d = err_d + dx_q;
  end : walk

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) busy_q <= 1'b0;
    else if (i_start) busy_q <= 1'b1;
    else if (at_end) busy_q <= 1'b0;  // last pixel goes out this cycle
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      cur_q   <= i_start_pt;
      end_q   <= i_end_pt;
      color_q <= i_color;
      x_inc_q <= !dx_raw[ERR_W-1];
      y_inc_q <= !dy_raw[ERR_W-1];
      dx_q    <= dx_abs;
      dy_q    <= dy_neg;
      err_q   <= dx_abs + dy_neg;
    end else if (busy_q && !at_end) begin
      err_q <= err_d;
      if (step_x) cur_q.x <= x_inc_q ? cur_q.x + 1'b1 : cur_q.x - 1'b1;
      if (step_y) cur_q.y <= y_inc_q ? cur_q.y + 1'b1 : cur_q.y - 1'b1;
    end
  end

  always_comb begin : drive_pix
    pix_out.pt    = cur_q;
    pix_out.color = color_q;
    pix.wr        = busy_q;
    pix.x         = pix_out.pt.x;
    pix.y         = pix_out.pt.y;
    pix.color     = pix_out.color;
    o_done        = busy_q && at_end;
  end : drive_pix

endmodule

`default_nettype wire

//--- hw/lda_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lda_defines.svh"

module lda_top (
  input  wire                      i_clk,
  input  wire                      i_reset,
  input  wire [`LDA_ADDR_W-1:0]    i_address,
  input  wire                      i_read,
  input  wire                      i_write,
  input  wire [`LDA_DATA_W-1:0]    i_writedata,
  output logic [`LDA_DATA_W-1:0]   o_readdata,
  output logic                     o_waitrequest,
  output logic                     o_pix_write,
  output logic [`LDA_X_W-1:0]      o_pix_x,
  output logic [`LDA_Y_W-1:0]      o_pix_y,
  output logic [`LDA_COLOR_W-1:0]  o_pix_color
);

  logic                      mode_ld;
  logic                      sp_ld;
  logic                      ep_ld;
  logic                      col_ld;
  logic                      status;
  logic                      start;
  logic                      done;
  lda_asc_pkg::lda_reg_t     rd_sel;
  lda_asc_pkg::lda_mode_t    mode;
  lda_pixel_pkg::lda_point_t start_pt;
  lda_pixel_pkg::lda_point_t end_pt;
  logic [`LDA_COLOR_W-1:0]   color;

  lda_pixel_if u_pix_if ();

  lda_asc_control u_control (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_address     (i_address),
    .i_read        (i_read),
    .i_write       (i_write),
    .i_done        (done),
    .i_mode        (mode),
    .o_start       (start),
    .o_waitrequest (o_waitrequest),
    .o_status      (status),
    .o_rd_sel      (rd_sel),
    .o_mode_ld     (mode_ld),
    .o_sp_ld       (sp_ld),
    .o_ep_ld       (ep_ld),
    .o_col_ld      (col_ld)
  );

  lda_asc_datapath u_datapath (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_writedata (i_writedata),
    .i_mode_ld   (mode_ld),
    .i_sp_ld     (sp_ld),
    .i_ep_ld     (ep_ld),
    .i_col_ld    (col_ld),
    .i_rd_sel    (rd_sel),
    .i_status    (status),
    .o_readdata  (o_readdata),
    .o_mode      (mode),
    .o_start_pt  (start_pt),
    .o_end_pt    (end_pt),
    .o_color     (color)
  );

  lda_line_engine u_engine (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_start    (start),
    .i_start_pt (start_pt),
    .i_end_pt   (end_pt),
    .i_color    (color),
    .o_done     (done),
    .pix        (u_pix_if.source)
  );

  // pixel port toward the external frame buffer
  assign o_pix_write = u_pix_if.wr;
  assign o_pix_x     = u_pix_if.x;
  assign o_pix_y     = u_pix_if.y;
  assign o_pix_color = u_pix_if.color;

endmodule

`default_nettype wire

//--- verification/lda_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lda_defines.svh"

module lda_tb;

  localparam int NCASE = 18;

  logic                     i_clk;
  logic                     i_reset;
  logic [`LDA_ADDR_W-1:0]   i_address;
  logic                     i_read;
  logic                     i_write;
  logic [`LDA_DATA_W-1:0]   i_writedata;
  logic [`LDA_DATA_W-1:0]   o_readdata;
  logic                     o_waitrequest;
  logic                     o_pix_write;
  logic [`LDA_X_W-1:0]      o_pix_x;
  logic [`LDA_Y_W-1:0]      o_pix_y;
  logic [`LDA_COLOR_W-1:0]  o_pix_color;

  // line table: start, end, color, mode
  int tab_sx [NCASE];
  int tab_sy [NCASE];
  int tab_ex [NCASE];
  int tab_ey [NCASE];
  int tab_col [NCASE];
  int tab_mode [NCASE];

  lda_pixel_pkg::lda_pixel_t got_q[$];
  lda_pixel_pkg::lda_pixel_t exp_q[$];
  int  errors = 0;
  int  tests_ok = 0;
  int  tests_bad = 0;
  int  cycles = 0;
  int  limit = 1000000;
  int  seed = 32'hf297;

  lda_top u_dut (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_address     (i_address),
    .i_read        (i_read),
    .i_write       (i_write),
    .i_writedata   (i_writedata),
    .o_readdata    (o_readdata),
    .o_waitrequest (o_waitrequest),
    .o_pix_write   (o_pix_write),
    .o_pix_x       (o_pix_x),
    .o_pix_y       (o_pix_y),
    .o_pix_color   (o_pix_color)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // collect pixels mid-cycle where they are stable
  always @(negedge i_clk) begin
    lda_pixel_pkg::lda_pixel_t p;
    if (!i_reset && o_pix_write) begin
      p.color = o_pix_color;
      p.pt.x  = o_pix_x;
      p.pt.y  = o_pix_y;
      got_q.push_back(p);
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run exceeded its cycle limit of %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [`LDA_DATA_W-1:0] got,
                            input logic [`LDA_DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_pixel(input string name, input lda_pixel_pkg::lda_pixel_t got,
                             input lda_pixel_pkg::lda_pixel_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] point_word(input int x, input int y);
    return (32'(y) << `LDA_PT_Y_LSB) | (32'(x) << `LDA_PT_X_LSB);
  endfunction

  function automatic int pixel_count(input int sx, input int sy, input int ex, input int ey);
    int ax;
    int ay;
    ax = (ex > sx) ? ex - sx : sx - ex;
    ay = (ey > sy) ? ey - sy : sy - ey;
    return ((ax > ay) ? ax : ay) + 1;
  endfunction

  // textbook error-term Bresenham
  task automatic ref_line(input int x0, input int y0, input int x1, input int y1, input int col);
    int dx;
    int dy;
    int sx;
    int sy;
    int err;
    int e2;
    lda_pixel_pkg::lda_pixel_t p;
    exp_q.delete();
    dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
    sx  = (x0 < x1) ? 1 : -1;
    sy  = (y0 < y1) ? 1 : -1;
    err = dx + dy;
    forever begin
      p.color = col;
      p.pt.x  = x0;
      p.pt.y  = y0;
      exp_q.push_back(p);
      if (x0 == x1 && y0 == y1) break;
      e2 = 2 * err;
      if (e2 >= dy) begin
        err += dy;
        x0  += sx;
      end
      if (e2 <= dx) begin
        err += dx;
        y0  += sy;
      end
    end
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [31:0] data, output int waits);
    logic held;
    waits       = 0;
    held        = 1'b1;
    i_address   = addr;
    i_writedata = data;
    i_write     = 1'b1;
    while (held) begin
      @(negedge i_clk);
      if (o_waitrequest) waits++;
      else held = 1'b0;
      @(posedge i_clk);
      #2;
    end
    i_write = 1'b0;
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [31:0] data);
    i_address = addr;
    i_read    = 1'b1;
    @(negedge i_clk);
    data = o_readdata;
    @(posedge i_clk);
    #2;
    i_read = 1'b0;
  endtask

  task automatic compare_pixels(input string tag);
    check_word({tag, " pixel count"}, got_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      if (i < got_q.size()) check_pixel({tag, " o_pix"}, got_q[i], exp_q[i]);
    end
  endtask

  // status is busy from the GO cycle through the last pixel cycle
  task automatic poll_until_idle(input string tag, input int go_cycle);
    logic [31:0] rd;
    int          polls;
    int          idx;
    polls = 0;
    rd    = 32'd1;
    while (rd != 0 && polls < 2000) begin
      check_word({tag, " o_waitrequest"}, o_waitrequest, 0);
      bus_read(3'd1, rd);
      idx = cycles - go_cycle - 1;  // cycle of the read, counted from GO
      check_word({tag, " o_readdata status"}, rd, (idx <= exp_q.size()) ? 32'd1 : 32'd0);
      polls++;
    end
    if (rd != 0) begin
      errors++;
      $display("%s: status never dropped back to idle", tag);
    end
  endtask

  task automatic draw(input int k);
    int waits;
    int n;
    int go_cycle;
    ref_line(tab_sx[k], tab_sy[k], tab_ex[k], tab_ey[k], tab_col[k]);
    n = exp_q.size();
    got_q.delete();
    go_cycle = cycles;
    bus_write(3'd2, 32'd1, waits);
    if (tab_mode[k] == 0) begin
      check_word("o_waitrequest cycles", waits, n + 1);
    end else begin
      check_word("o_waitrequest cycles", waits, 0);
      poll_until_idle("poll", go_cycle);
    end
    compare_pixels("line");
  endtask

  task automatic load_line(input int k);
    int w;
    bus_write(3'd0, tab_mode[k], w);
    bus_write(3'd3, point_word(tab_sx[k], tab_sy[k]), w);
    bus_write(3'd4, point_word(tab_ex[k], tab_ey[k]), w);
    bus_write(3'd5, tab_col[k], w);
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAIL", name);
    end
  endtask

  task automatic set_case(input int k, input int sx, input int sy, input int ex, input int ey);
    tab_sx[k]   = sx;
    tab_sy[k]   = sy;
    tab_ex[k]   = ex;
    tab_ey[k]   = ey;
    tab_col[k]  = (k % 7) + 1;
    tab_mode[k] = k % 2;
  endtask

  initial begin
    logic [31:0] rd;
    int          e0;
    int          w;
    int          go_cycle;
    i_reset     = 1'b1;
    i_address   = '0;
    i_read      = 1'b0;
    i_write     = 1'b0;
    i_writedata = '0;

    // eight octants around one center, then the corner cases
    set_case(0, 256, 128, 300, 140);
    set_case(1, 256, 128, 270, 180);
    set_case(2, 256, 128, 240, 190);
    set_case(3, 256, 128, 200, 140);
    set_case(4, 256, 128, 210, 110);
    set_case(5, 256, 128, 240, 60);
    set_case(6, 256, 128, 270, 70);
    set_case(7, 256, 128, 310, 115);
    set_case(8, 10, 20, 100, 20);     // horizontal
    set_case(9, 50, 200, 50, 30);     // vertical
    set_case(10, 0, 0, 40, 40);       // 45 degrees
    set_case(11, 7, 7, 7, 7);         // single point
    for (int k = 12; k < NCASE; k++) begin
      set_case(k, $unsigned($random(seed)) % 512, $unsigned($random(seed)) % 256,
               $unsigned($random(seed)) % 512, $unsigned($random(seed)) % 256);
    end
    limit = 300 + pixel_count(10, 10, 200, 50) + pixel_count(10, 10, 20, 90) + 40;
    for (int k = 0; k < NCASE; k++) begin
      limit += pixel_count(tab_sx[k], tab_sy[k], tab_ex[k], tab_ey[k]) + 20;
    end

    repeat (5) @(posedge i_clk);
    #2;
    i_reset = 1'b0;

    e0 = errors;
    check_word("o_waitrequest", o_waitrequest, 0);
    check_word("o_pix_write", o_pix_write, 0);
    for (int a = 0; a < 8; a++) begin
      bus_read(a, rd);
      check_word("o_readdata", rd, 0);
    end
    finish_test("reset state", e0);

    e0 = errors;
    bus_write(3'd0, 32'hffff_ffff, w);
    bus_write(3'd3, 32'hdead_beef, w);
    bus_write(3'd4, 32'h1234_5678, w);
    bus_write(3'd5, 32'hffff_fffe, w);
    bus_write(3'd1, 32'h0000_0000, w);  // status is read only
    bus_write(3'd6, 32'h0000_0000, w);
    bus_write(3'd7, 32'h0000_0000, w);
    bus_read(3'd0, rd);
    check_word("o_readdata mode", rd, 32'd1);
    bus_read(3'd3, rd);
    check_word("o_readdata start point", rd, 32'hdead_beef & 32'h1ffff);
    bus_read(3'd4, rd);
    check_word("o_readdata end point", rd, 32'h1234_5678 & 32'h1ffff);
    bus_read(3'd5, rd);
    check_word("o_readdata color", rd, 32'd6);
    bus_read(3'd1, rd);
    check_word("o_readdata status", rd, 32'd0);
    for (int a = 2; a < 8; a = (a == 2) ? 6 : a + 1) begin
      bus_read(a, rd);
      check_word("o_readdata unmapped or go", rd, 0);
    end
    finish_test("register readback", e0);

    for (int k = 0; k < NCASE; k++) begin
      e0 = errors;
      load_line(k);
      draw(k);
      finish_test($sformatf("line %0d (%0d,%0d)->(%0d,%0d) mode %0d", k, tab_sx[k],
                  tab_sy[k], tab_ex[k], tab_ey[k], tab_mode[k]), e0);
    end

    // rewrite end and color while a poll-mode line runs
    e0 = errors;
    bus_write(3'd0, 32'd1, w);
    bus_write(3'd3, point_word(10, 10), w);
    bus_write(3'd4, point_word(200, 50), w);
    bus_write(3'd5, 32'd5, w);
    ref_line(10, 10, 200, 50, 5);
    got_q.delete();
    go_cycle = cycles;
    bus_write(3'd2, 32'd1, w);
    bus_write(3'd4, point_word(20, 90), w);
    bus_write(3'd5, 32'd2, w);
    poll_until_idle("isolation", go_cycle);
    compare_pixels("isolation first");
    ref_line(10, 10, 20, 90, 2);
    got_q.delete();
    go_cycle = cycles;
    bus_write(3'd2, 32'd1, w);
    poll_until_idle("isolation", go_cycle);
    compare_pixels("isolation second");
    finish_test("latch isolation", e0);

    $display("tests passed %0d failed %0d checks failed %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/lda_asc_pkg.sv
hw/lda_pixel_pkg.sv
hw/lda_pixel_if.sv
hw/lda_asc_control.sv
hw/lda_asc_datapath.sv
hw/lda_line_engine.sv
hw/lda_top.sv
verification/lda_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= lda_tb
RTL_TOP   ?= lda_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
